/* axis_pixels.sv */
`timescale 1ns/1ps
`include "pixels_macros.svh"

module axis_pixels (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  pixels_stream_pkg::in_beat_t   s_beat,
  input  logic                          s_valid,
  output logic                          s_ready,
  output pixels_stream_pkg::row_words_t m_data,
  output logic                          m_valid,
  output logic                          m_last,
  input  logic                          m_ready
);

  import pixels_stream_pkg::*;
  import pixels_cfg_pkg::*;

  localparam int SHIFT_WORDS = `ROWS + `KH_MAX - 1;

  pix_state_t                  state;
  logic [`S_WORDS*`X_BITS-1:0] s_flat;
  cfg_t                        cfg_in;
  kh2_t                        kh2_r;

  col_beat_t ad_beat;
  logic      ad_s_valid, ad_s_ready, ad_m_valid, ad_m_ready;

  logic en_config, en_shift, en_kh, en_copy, col_live, tok_valid;
  logic last_kh, last_clk_kh, last_clk_ci, last_clk_w, last_l, first_l;
  logic s_last_beat, m_last_beat;

  col_beat_t   col_r;
  logic        tok_valid_r, load_r, first_l_r, last_l_r;
  edge_addr_t  ram_addr, ram_addr_r, ram_addr_in;
  logic        ram_on, ram_ren, ram_wen, ram_ren_r;
  edge_words_t ram_dout, ram_hold, ram_dout_r, edge_top, edge_bot;

  x_word_t [SHIFT_WORDS-1:0] shift_reg;

  axis_width_adapter adapter0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_beat  (s_beat),
    .s_valid (ad_s_valid),
    .s_ready (ad_s_ready),
    .m_beat  (ad_beat),
    .m_valid (ad_m_valid),
    .m_ready (ad_m_ready)
  );

  assign s_flat = s_beat.data;
  assign cfg_in = cfg_t'(s_flat[$bits(cfg_t)-1:0]);

  assign s_last_beat = s_valid && s_ready && s_beat.last;
  assign m_last_beat = m_valid && m_ready && m_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= set;
    end else begin
      case (state)
        set: begin
          if (s_valid && s_ready) begin
            state <= pass;
          end
        end
        pass: begin
          if (s_last_beat) begin
            state <= m_last_beat ? set : block;
          end
        end
        block: begin
          if (m_last_beat) begin
            state <= set;
          end
        end
        default: begin
          state <= set;
        end
      endcase
    end
  end

  always_comb begin
    en_config  = 1'b0;
    s_ready    = 1'b0;
    ad_s_valid = 1'b0;
    case (state)
      set: begin
        en_config = 1'b1;
        s_ready   = 1'b1;
      end
      pass: begin
        s_ready    = ad_s_ready;
        ad_s_valid = s_valid;
      end
      default: begin
        // Waiting for the last output
        s_ready = 1'b0;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (en_config && s_valid) begin
      kh2_r <= cfg_in.kh2;
    end
  end

  // Pipeline moves when the output slot is empty or taken
  assign en_shift = m_ready || !m_valid;

  // At the last kernel step the counter waits for a new column
  assign en_kh      = en_shift && !en_config && (!last_kh || ad_m_valid);
  assign en_copy    = last_clk_kh;
  assign ad_m_ready = en_copy;

  // Steps before the first column of a packet are idle
  assign tok_valid = en_kh && (last_kh || col_live);

  always_ff @(posedge aclk) begin
    if (!aresetn || en_config) begin
      col_live <= 1'b0;
    end else if (en_copy) begin
      col_live <= 1'b1;
    end
  end

  loop_counter #(.W($bits(kh_t))) kh_cnt (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (en_kh),
    .max_in   (kh_t'(2 * cfg_in.kh2)),
    .last_clk (last_clk_kh),
    .last     (last_kh),
    .first    ()
  );

  loop_counter #(.W($bits(ci_t))) ci_cnt (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (last_clk_kh),
    .max_in   (cfg_in.channels),
    .last_clk (last_clk_ci),
    .last     (),
    .first    ()
  );

  loop_counter #(.W($bits(xw_t))) xw_cnt (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (last_clk_ci),
    .max_in   (cfg_in.width),
    .last_clk (last_clk_w),
    .last     (),
    .first    ()
  );

  loop_counter #(.W($bits(blocks_t))) blk_cnt (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (last_clk_w),
    .max_in   (cfg_in.blocks),
    .last_clk (),
    .last     (last_l),
    .first    (first_l)
  );

  // One RAM entry per column and channel of a block
  always_ff @(posedge aclk) begin
    if (!aresetn || en_config || last_clk_w) begin
      ram_addr <= '0;
    end else if (en_copy) begin
      ram_addr <= ram_addr + 1'b1;
    end
  end

  // Edges are not used by a single-row kernel
  assign ram_on      = (kh2_r != '0);
  assign ram_ren     = en_copy && !first_l && ram_on;
  assign ram_wen     = load_r && !last_l_r && ram_on;
  assign ram_addr_in = ram_wen ? ram_addr_r : ram_addr;

  edge_ram ram0 (
    .aclk (aclk),
    .en   (ram_ren || ram_wen),
    .we   (ram_wen),
    .addr (ram_addr_in),
    .din  (edge_bot),
    .dout (ram_dout)
  );

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ram_ren_r <= 1'b0;
    end else begin
      ram_ren_r <= ram_ren;
    end
  end

  // Keeps the read word once a write or a stall follows it
  always_ff @(posedge aclk) begin
    if (ram_ren_r) begin
      ram_hold <= ram_dout;
    end
  end

  assign ram_dout_r = ram_ren_r ? ram_dout : ram_hold;
  assign edge_top   = (first_l_r || !ram_on) ? '0 : ram_dout_r;
  assign edge_bot   = col_r.data[`ROWS-1 -: EDGE_WORDS];

  // Stage aligned with the RAM read
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tok_valid_r <= 1'b0;
      load_r      <= 1'b0;
    end else if (en_shift) begin
      tok_valid_r <= tok_valid;
      load_r      <= en_copy;
    end
  end

  always_ff @(posedge aclk) begin
    if (en_copy) begin
      col_r      <= ad_beat;
      first_l_r  <= first_l;
      last_l_r   <= last_l;
      ram_addr_r <= ram_addr;
    end
  end

  always_ff @(posedge aclk) begin
    if (en_shift) begin
      if (load_r) begin
        shift_reg <= {col_r.data, edge_top};
      end else begin
        shift_reg <= {x_word_t'(0), shift_reg[SHIFT_WORDS-1:1]};
      end
    end
  end

  // Kernel counter already shows the step held in the stage
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (en_shift) begin
      m_valid <= tok_valid_r;
      m_last  <= tok_valid_r && col_r.last && last_kh;
    end
  end

  always_comb begin
    for (int r = 0; r < `ROWS; r++) begin
      m_data[r] = shift_reg[r + EDGE_WORDS - int'(kh2_r)];
    end
  end

endmodule

/* axis_width_adapter.sv */
`timescale 1ns/1ps
`include "pixels_macros.svh"

module axis_width_adapter (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  pixels_stream_pkg::in_beat_t  s_beat,
  input  logic                         s_valid,
  output logic                         s_ready,
  output pixels_stream_pkg::col_beat_t m_beat,
  output logic                         m_valid,
  input  logic                         m_ready
);

  import pixels_stream_pkg::*;

  // Room for a partial column plus one full input beat
  localparam int BUF_WORDS = COL_WORDS + `S_WORDS - 1;
  localparam int CNT_BITS  = $clog2(BUF_WORDS + 1);

  x_word_t [BUF_WORDS-1:0] gather;
  x_word_t [BUF_WORDS-1:0] gather_in;
  logic [CNT_BITS-1:0]     count;
  logic [CNT_BITS-1:0]     count_in;
  logic                    last_held;
  logic                    s_beat_ok;
  logic                    m_beat_ok;

  assign s_beat_ok = s_valid && s_ready;
  assign m_beat_ok = m_valid && m_ready;

  // Kept words go in order behind the words already held
  always_comb begin
    gather_in = gather;
    count_in  = count;
    for (int i = 0; i < `S_WORDS; i++) begin
      if (s_beat.keep[i]) begin
        gather_in[count_in] = s_beat.data[i];
        count_in            = count_in + 1'b1;
      end
    end
  end

  // Never takes input while a column is presented
  assign s_ready = (count < CNT_BITS'(COL_WORDS));
  assign m_valid = (count >= CNT_BITS'(COL_WORDS));

  assign m_beat.data = gather[COL_WORDS-1:0];
  // Only the column holding the final word
  assign m_beat.last = last_held && (count == CNT_BITS'(COL_WORDS));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count     <= '0;
      last_held <= 1'b0;
    end else if (m_beat_ok) begin
      count <= count - CNT_BITS'(COL_WORDS);
      if (m_beat.last) begin
        last_held <= 1'b0;
      end
    end else if (s_beat_ok) begin
      count <= count_in;
      if (s_beat.last) begin
        last_held <= 1'b1;
      end
    end
  end

  // Remainder moves down to the bottom of the buffer
  always_ff @(posedge aclk) begin
    if (m_beat_ok) begin
      gather <= gather >> (COL_WORDS * `X_BITS);
    end else if (s_beat_ok) begin
      gather <= gather_in;
    end
  end

endmodule

/* edge_ram.sv */
`timescale 1ns/1ps
`include "pixels_macros.svh"

module edge_ram (
  input  logic                           aclk,
  input  logic                           en,
  input  logic                           we,
  input  pixels_stream_pkg::edge_addr_t  addr,
  input  pixels_stream_pkg::edge_words_t din,
  output pixels_stream_pkg::edge_words_t dout
);

  import pixels_stream_pkg::*;

  edge_words_t mem [`RAM_EDGES_DEPTH];

  // Read first, so a write returns the old entry
  always_ff @(posedge aclk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end
      dout <= mem[addr];
    end
  end

endmodule

/* files.f */
+incdir+.
pixels_stream_pkg.sv
pixels_cfg_pkg.sv
loop_counter.sv
edge_ram.sv
axis_width_adapter.sv
axis_pixels.sv
pixels_top.sv
pixels_tb.sv

/* loop_counter.sv */
`timescale 1ns/1ps
`include "pixels_macros.svh"

module loop_counter #(
  parameter int W = 2
) (
  input  logic         aclk,
  input  logic         clear,
  input  logic         en,
  input  logic [W-1:0] max_in,
  output logic         last_clk,
  output logic         last,
  output logic         first
);

  logic [W-1:0] count;
  logic [W-1:0] max_r;

  always_ff @(posedge aclk) begin
    if (clear) begin
      count <= '0;
      max_r <= max_in;
    end else if (en) begin
      if (last) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign last  = (count == max_r);
  assign first = (count == '0);

  // Steps the next loop out
  assign last_clk = last && en;

endmodule

/* pixels_cfg_pkg.sv */
`include "pixels_macros.svh"

package pixels_cfg_pkg;

  // Kernel step counter runs 0 .. 2*kh2
  typedef logic [$clog2(`KH_MAX)-1:0] kh_t;
  typedef logic [$clog2((`KH_MAX + 1) / 2)-1:0] kh2_t;
  typedef logic [$clog2(`CI_MAX)-1:0] ci_t;
  typedef logic [$clog2(`XW_MAX)-1:0] xw_t;
  typedef logic [$clog2(`XH_MAX / `ROWS)-1:0] blocks_t;

  // Low bits of the first beat, all but kh2 stored minus one
  typedef struct packed {
    blocks_t blocks;
    xw_t     width;
    ci_t     channels;
    kh2_t    kh2;
  } cfg_t;

  typedef enum logic [1:0] {
    set,
    pass,
    block
  } pix_state_t;

endpackage

/* pixels_macros.svh */
`ifndef PIXELS_MACROS_SVH
`define PIXELS_MACROS_SVH

// Rows per block and kernel limits
`define ROWS 4
`define KH_MAX 3

// Image limits
`define CI_MAX 4
`define XW_MAX 8
`define XH_MAX 16

// Pixel word width in bits
`define X_BITS 8

// Words per input stream beat
`define S_WORDS 4

// One bottom edge per column and channel
`define RAM_EDGES_DEPTH (`XW_MAX * `CI_MAX)

`endif

/* pixels_stream_pkg.sv */
`include "pixels_macros.svh"

package pixels_stream_pkg;

  // Rows below the block that a full window needs
  localparam int EDGE_WORDS = `KH_MAX / 2;
  localparam int COL_WORDS  = `ROWS + EDGE_WORDS;

  typedef logic [`X_BITS-1:0] x_word_t;

  typedef struct packed {
    x_word_t [`S_WORDS-1:0] data;
    logic    [`S_WORDS-1:0] keep;
    logic                   last;
  } in_beat_t;

  typedef x_word_t [COL_WORDS-1:0] col_words_t;

  typedef struct packed {
    col_words_t data;
    logic       last;
  } col_beat_t;

  typedef x_word_t [`ROWS-1:0] row_words_t;

  typedef x_word_t [EDGE_WORDS-1:0] edge_words_t;

  typedef logic [$clog2(`RAM_EDGES_DEPTH)-1:0] edge_addr_t;

endpackage

/* pixels_tb.sv */
`timescale 1ns/1ps
`include "pixels_macros.svh"

module pixels_tb;

  import pixels_stream_pkg::*;
  import pixels_cfg_pkg::*;

  localparam int TIMEOUT   = 1000;
  localparam int E_WORDS   = EDGE_WORDS + COL_WORDS;
  localparam int READY_LEN = 4096;

  logic       aclk = 1'b0;
  logic       aresetn;
  in_beat_t   s_beat;
  logic       s_valid;
  logic       s_ready;
  row_words_t m_data;
  logic       m_valid;
  logic       m_last;
  logic       m_ready;

  integer     seed;
  x_word_t    pix[$];
  in_beat_t   beats[$];
  int         gap_q[$];
  bit         ready_q[$];
  row_words_t exp_data[$];
  bit         exp_last[$];

  always #2 aclk = ~aclk;

  pixels_top dut0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_data  (m_data),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_ready (m_ready)
  );

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Gave up waiting: %s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic make_pixels(input int n);
    pix.delete();
    for (int i = 0; i < n; i++) begin
      pix.push_back(x_word_t'($random(seed)));
    end
  endtask

  // Header fields other than kh2 are stored minus one
  task automatic make_cfg_beat(input int kh2, input int ch, input int wd, input int nb,
                               output in_beat_t b);
    cfg_t                        c;
    logic [`S_WORDS*`X_BITS-1:0] flat;
    c.kh2      = kh2_t'(kh2);
    c.channels = ci_t'(ch - 1);
    c.width    = xw_t'(wd - 1);
    c.blocks   = blocks_t'(nb - 1);
    flat       = '0;
    flat[$bits(cfg_t)-1:0] = c;
    b.data = flat;
    b.keep = '1;
    b.last = 1'b0;
  endtask

  // Unkept slots carry random junk
  task automatic build_beats(input bit sparse, input bit gaps);
    int                  idx;
    logic [`S_WORDS-1:0] keep;
    in_beat_t            b;
    beats.delete();
    gap_q.delete();
    idx = 0;
    while (idx < pix.size()) begin
      b.data = $random(seed);
      b.keep = '0;
      if (sparse) begin
        keep = $random(seed);
      end else begin
        keep = '1;
      end
      for (int i = 0; i < `S_WORDS; i++) begin
        if (keep[i] && idx < pix.size()) begin
          b.data[i] = pix[idx];
          b.keep[i] = 1'b1;
          idx++;
        end
      end
      b.last = (idx == pix.size());
      beats.push_back(b);
      gap_q.push_back(gaps ? {$random(seed)} % 3 : 0);
    end
  endtask

  task automatic build_ready(input int pct);
    ready_q.delete();
    for (int i = 0; i < READY_LEN; i++) begin
      ready_q.push_back(({$random(seed)} % 100) < pct);
    end
  endtask

  // Window rows at step k are E[r + k + EDGE_WORDS - kh2] with E = {top edge, column}
  function automatic void build_expected(input int kh2, input int ch, input int wd,
                                         input int nb);
    int         ncol;
    int         per_block;
    x_word_t    e [E_WORDS];
    row_words_t row;
    ncol      = ch * wd * nb;
    per_block = ch * wd;
    exp_data.delete();
    exp_last.delete();
    for (int j = 0; j < ncol; j++) begin
      for (int t = 0; t < EDGE_WORDS; t++) begin
        if (j < per_block) begin
          e[t] = '0;
        end else begin
          e[t] = pix[(j - per_block) * COL_WORDS + `ROWS - EDGE_WORDS + t];
        end
      end
      for (int i = 0; i < COL_WORDS; i++) begin
        e[EDGE_WORDS + i] = pix[j * COL_WORDS + i];
      end
      for (int k = 0; k <= 2 * kh2; k++) begin
        for (int r = 0; r < `ROWS; r++) begin
          row[r] = e[r + k + EDGE_WORDS - kh2];
        end
        exp_data.push_back(row);
        exp_last.push_back(1'b0);
      end
    end
    exp_last[exp_last.size()-1] = 1'b1;
  endfunction

  task automatic send_beat(input string name, input in_beat_t b);
    int waited;
    bit taken;
    s_beat  = b;
    s_valid = 1'b1;
    waited  = 0;
    taken   = 1'b0;
    while (!taken) begin
      @(negedge aclk);
      taken = s_ready;
      @(posedge aclk);
      #1;
      waited++;
      if (!taken && waited > TIMEOUT) begin
        fail_timeout($sformatf("s_ready stayed low during %s", name));
      end
    end
    s_valid = 1'b0;
  endtask

  task automatic send_packet(input string name, input in_beat_t cfg_beat);
    send_beat(name, cfg_beat);
    for (int i = 0; i < beats.size(); i++) begin
      repeat (gap_q[i]) begin
        @(posedge aclk);
        #1;
      end
      send_beat(name, beats[i]);
    end
  endtask

  task automatic collect_outputs(input string name);
    int idx;
    int idle;
    int cyc;
    idx  = 0;
    idle = 0;
    cyc  = 0;
    while (idx < exp_data.size()) begin
      m_ready = ready_q[cyc % READY_LEN];
      cyc++;
      @(negedge aclk);
      if (m_valid && m_ready) begin
        check_equal($sformatf("%s out %0d m_data", name, idx), exp_data[idx], m_data);
        check_equal($sformatf("%s out %0d m_last", name, idx), exp_last[idx], m_last);
        idx++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          fail_timeout($sformatf("no output transfer during %s", name));
        end
      end
      @(posedge aclk);
      #1;
    end
    m_ready = 1'b1;
  endtask

  // Nothing extra may follow the last output, and the FSM is back in set
  task automatic expect_idle(input string name);
    repeat (8) begin
      @(negedge aclk);
      check_equal({name, " idle m_valid"}, 1'b0, m_valid);
      check_equal({name, " idle s_ready"}, 1'b1, s_ready);
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic run_packet(input string name, input int kh2, input int ch, input int wd,
                            input int nb, input bit sparse, input bit gaps,
                            input int ready_pct);
    in_beat_t cfg_beat;
    make_cfg_beat(kh2, ch, wd, nb, cfg_beat);
    build_beats(sparse, gaps);
    build_ready(ready_pct);
    build_expected(kh2, ch, wd, nb);
    fork
      send_packet(name, cfg_beat);
      collect_outputs(name);
    join
    expect_idle(name);
  endtask

  task automatic test_reset();
    @(negedge aclk);
    check_equal("reset m_valid", 1'b0, m_valid);
    check_equal("reset m_last", 1'b0, m_last);
    check_equal("reset s_ready", 1'b1, s_ready);
    @(posedge aclk);
    #1;
  endtask

  task automatic test_kernel_1();
    make_pixels(2 * 2 * 1 * COL_WORDS);
    run_packet("kernel_1", 0, 2, 2, 1, 1'b0, 1'b0, 100);
  endtask

  task automatic test_kernel_3();
    make_pixels(2 * 3 * 1 * COL_WORDS);
    run_packet("kernel_3", 1, 2, 3, 1, 1'b0, 1'b0, 100);
  endtask

  task automatic test_blocks();
    make_pixels(2 * 2 * 3 * COL_WORDS);
    run_packet("blocks", 1, 2, 2, 3, 1'b0, 1'b0, 100);
    make_pixels(1 * 3 * 2 * COL_WORDS);
    run_packet("blocks second packet", 1, 1, 3, 2, 1'b0, 1'b0, 100);
  endtask

  task automatic test_backpressure();
    make_pixels(3 * 4 * 2 * COL_WORDS);
    run_packet("backpressure", 1, 3, 4, 2, 1'b0, 1'b1, 60);
  endtask

  // Same pixels twice, dense beats first and then random keep patterns
  task automatic test_sparse();
    make_pixels(2 * 3 * 2 * COL_WORDS);
    run_packet("sparse dense run", 1, 2, 3, 2, 1'b0, 1'b0, 100);
    run_packet("sparse keep run", 1, 2, 3, 2, 1'b1, 1'b1, 70);
  endtask

  initial begin
    seed    = 32'heb1c;
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b0;
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    test_reset();
    test_kernel_1();
    test_kernel_3();
    test_blocks();
    test_backpressure();
    test_sparse();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* pixels_top.sv */
`timescale 1ns/1ps
`include "pixels_macros.svh"

module pixels_top (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  pixels_stream_pkg::in_beat_t   s_beat,
  input  logic                          s_valid,
  output logic                          s_ready,
  output pixels_stream_pkg::row_words_t m_data,
  output logic                          m_valid,
  output logic                          m_last,
  input  logic                          m_ready
);

  axis_pixels pixels0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_data  (m_data),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_ready (m_ready)
  );

endmodule
